/* verif/dma_engine_tests.txt */
// op queue len avail_mask nf_mask exp_ack nf_hold, all hex
// op 1 tx 2 rx, ack 1 tx 2 rx 3 reject
1 0 040 f 0 1 0
1 1 00d f 0 1 0
2 2 020 f 0 3 0
2 2 020 f 0 2 0
2 3 01e 7 0 3 0
1 2 006 f 4 3 0
2 0 007 f 0 2 6
1 3 003 f 0 1 0
1 3 005 f 0 1 0
1 0 00a f 0 3 0
2 1 031 f 0 2 10
2 1 011 d 0 3 0
1 1 0fe 0 0 1 0
1 2 001 0 b 1 0
1 3 022 0 8 3 0
2 3 040 f 0 2 20
2 0 004 f f 2 3
1 0 07f f 0 1 0
2 2 002 f 0 2 0

/* sim.f */
hdl/dma_pkg.sv
hdl/dma_cmd_if.sv
hdl/dma_word_fifo.sv
hdl/dma_op_decode.sv
hdl/dma_xfer_exec.sv
hdl/dma_stat_result.sv
hdl/dma_engine.sv
verif/dma_engine_tb.sv

/* verif/dma_engine_tb.sv */
// DMA engine testbench with clock, reset, CPU queue models and file-driven ops
// compare tasks, register readback and watchdog
`timescale 1ns/1ns

module dma_engine_tb
   import dma_pkg::*;
();

   localparam int max_lines  = 64;
   localparam int line_words = 7;

   logic                  cpci_clk;
   logic                  rst_n;
   dma_op_e               dma_op_code_req;
   logic [queue_w-1:0]    dma_op_queue_id;
   dma_ack_e              dma_op_code_ack;
   logic                  dma_vld_c2n;
   logic [data_w-1:0]     dma_data_c2n;
   logic                  dma_vld_n2c;
   logic [data_w-1:0]     dma_data_n2c;
   logic                  dma_dest_q_nearly_full_c2n;
   logic [num_queues-1:0] cpu_q_dma_pkt_avail;
   logic                  cpu_q_dma_rd;
   logic [queue_w-1:0]    cpu_q_dma_rd_queue;
   logic [data_w-1:0]     cpu_q_dma_rd_data;
   logic [ctrl_w-1:0]     cpu_q_dma_rd_ctrl;
   logic [num_queues-1:0] cpu_q_dma_nearly_full;
   logic                  cpu_q_dma_wr;
   logic [queue_w-1:0]    cpu_q_dma_wr_queue;
   logic [data_w-1:0]     cpu_q_dma_wr_data;
   logic [ctrl_w-1:0]     cpu_q_dma_wr_ctrl;
   logic                  cpu_q_dma_wr_pkt_vld;
   logic                  reg_req;
   stat_reg_e             reg_addr;
   logic                  reg_ack;
   logic [stat_w-1:0]     reg_rd_data;

   // test table, seven hex fields per line
   logic [15:0]       test_mem [max_lines*line_words];
   int                line_cnt;
   logic [31:0]       rng_state = 32'd22;
   // rx queue models and expected words on each output
   queue_word_t       rx_model [num_queues][$];
   queue_word_t       tx_expect[$];
   logic [queue_w-1:0] tx_expect_q;
   logic [data_w-1:0] n2c_expect[$];
   logic              rd_pending;
   logic [queue_w-1:0] rd_pending_q;
   logic              nf_last;
   logic [stat_w-1:0] exp_stat[5];

   dma_engine i_dma_engine (.*);

   initial begin
      cpci_clk = 1'b0;
      forever #4 cpci_clk = ~cpci_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // helpers and compare tasks
   //////////////////////////////////////////////////////////////////////

   // linear congruential generator
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   // last valid byte mark from length mod 4
   function automatic logic [ctrl_w-1:0] end_mark(input logic [len_w-1:0] len);
      case (len % 4)
         1:       return 4'b1000;
         2:       return 4'b0100;
         3:       return 4'b0010;
         default: return 4'b0001;
      endcase
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_ack(input string name, input dma_ack_e got, input dma_ack_e exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: %s got %s expected %s",
                            $time, name, got.name(), exp.name()));
   endtask

   task automatic check_queue_word(input string name, input queue_word_t got,
                                   input queue_word_t exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_n2c(input string name, input logic [data_w-1:0] got,
                            input logic [data_w-1:0] exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_stat(input string name, input logic [stat_w-1:0] got,
                             input logic [stat_w-1:0] exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // output monitors and rx queue model, sampled at the falling edge
   //////////////////////////////////////////////////////////////////////

   always @(negedge cpci_clk) begin
      if (rst_n && cpu_q_dma_wr) begin
         if (tx_expect.size() == 0)
            stop_run("tx queue write seen with no packet expected");
         check_queue_word("cpu_q_dma_wr_data/ctrl", {cpu_q_dma_wr_data, cpu_q_dma_wr_ctrl},
                          tx_expect[0]);
         check_stat("cpu_q_dma_wr_queue", stat_w'(cpu_q_dma_wr_queue), stat_w'(tx_expect_q));
         check_flag("cpu_q_dma_wr_pkt_vld", cpu_q_dma_wr_pkt_vld, tx_expect[0].ctrl != '0);
         void'(tx_expect.pop_front());
      end else if (rst_n) begin
         check_flag("cpu_q_dma_wr_pkt_vld", cpu_q_dma_wr_pkt_vld, 1'b0);
      end
      // no word may follow a cycle with nearly_full high
      if (rst_n && dma_vld_n2c) begin
         if (nf_last)
            stop_run("n2c word sent while dma_dest_q_nearly_full_c2n was high");
         if (n2c_expect.size() == 0)
            stop_run("n2c word seen with no rx packet expected");
         check_n2c("dma_data_n2c", dma_data_n2c, n2c_expect.pop_front());
      end
      nf_last = dma_dest_q_nearly_full_c2n;
      if (rst_n && cpu_q_dma_rd) begin
         rd_pending   = 1'b1;
         rd_pending_q = cpu_q_dma_rd_queue;
      end
   end

   // queue answers one cycle after the read strobe
   always @(posedge cpci_clk) begin
      #1;
      if (rd_pending) begin
         rd_pending = 1'b0;
         if (rx_model[rd_pending_q].size() == 0)
            stop_run("rx queue read while the queue model was empty");
         {cpu_q_dma_rd_data, cpu_q_dma_rd_ctrl} = rx_model[rd_pending_q].pop_front();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic issue_op(input dma_op_e op, input logic [queue_w-1:0] q,
                           input dma_ack_e exp_ack);
      dma_op_code_req = op;
      dma_op_queue_id = q;
      @(posedge cpci_clk) #1;
      dma_op_code_req = op_none;
      check_ack("dma_op_code_ack", dma_op_code_ack, exp_ack);
      @(posedge cpci_clk) #1;
      check_ack("dma_op_code_ack", dma_op_code_ack, ack_none);
   endtask

   // builds one packet, length in bits 10:0 of the first word
   task automatic build_packet(input logic [len_w-1:0] len, output queue_word_t pkt[$]);
      int          n;
      queue_word_t w;
      n = (len + 3) / 4;
      pkt = {};
      for (int k = 0; k < n; k++) begin
         w.data = next_rand();
         if (k == 0)
            w.data[len_w-1:0] = len;
         w.ctrl = (k == n - 1) ? end_mark(len) : '0;
         pkt.push_back(w);
      end
   endtask

   task automatic send_c2n(input logic [data_w-1:0] d);
      dma_vld_c2n  = 1'b1;
      dma_data_c2n = d;
      @(posedge cpci_clk) #1;
      dma_vld_c2n  = 1'b0;
      repeat (next_rand() % 3) @(posedge cpci_clk) #1;
   endtask

   // tx words follow a separate length word
   task automatic run_tx(input logic [queue_w-1:0] q, input logic [len_w-1:0] len);
      queue_word_t pkt[$];
      build_packet(len, pkt);
      tx_expect_q = q;
      foreach (pkt[k])
         tx_expect.push_back(pkt[k]);
      send_c2n({next_rand() & ~32'h7ff} | data_w'(len));
      foreach (pkt[k])
         send_c2n(pkt[k].data);
   endtask

   // masks alone would accept, so only busy can reject
   function automatic bit busy_line(input int i);
      logic [15:0] op;
      logic [15:0] q;
      op = test_mem[i*line_words];
      q  = test_mem[i*line_words+1];
      return (test_mem[i*line_words+5] == 16'h3) &&
             ((op == 16'h1 && !test_mem[i*line_words+4][q]) ||
              (op == 16'h2 && test_mem[i*line_words+3][q]));
   endfunction

   initial begin
      dma_op_code_req            = op_none;
      dma_op_queue_id            = '0;
      dma_vld_c2n                = 1'b0;
      dma_data_c2n               = '0;
      dma_dest_q_nearly_full_c2n = 1'b0;
      cpu_q_dma_pkt_avail        = '0;
      cpu_q_dma_rd_data          = '0;
      cpu_q_dma_rd_ctrl          = '0;
      cpu_q_dma_nearly_full      = '0;
      reg_req                    = 1'b0;
      reg_addr                   = reg_tx_pkts;
      rd_pending                 = 1'b0;
      nf_last                    = 1'b0;
      rst_n                      = 1'b0;
      foreach (exp_stat[k])
         exp_stat[k] = '0;
      foreach (test_mem[k])
         test_mem[k] = 16'hffff;
      $readmemh("verif/dma_engine_tests.txt", test_mem);
      line_cnt = 0;
      while (line_cnt < max_lines && test_mem[line_cnt*line_words] != 16'hffff)
         line_cnt++;
      repeat (8) @(posedge cpci_clk);
      #1;
      rst_n = 1'b1;
      @(posedge cpci_clk) #1;

      for (int i = 0; i < line_cnt; i++) begin
         dma_op_e          op;
         logic [queue_w-1:0] q;
         logic [len_w-1:0] len;
         dma_ack_e         ack;
         int               hold;
         queue_word_t      pkt[$];
         op   = dma_op_e'(test_mem[i*line_words][1:0]);
         q    = test_mem[i*line_words+1][queue_w-1:0];
         len  = test_mem[i*line_words+2][len_w-1:0];
         ack  = dma_ack_e'(test_mem[i*line_words+5][1:0]);
         hold = test_mem[i*line_words+6];
         cpu_q_dma_pkt_avail   = test_mem[i*line_words+3][num_queues-1:0];
         cpu_q_dma_nearly_full = test_mem[i*line_words+4][num_queues-1:0];
         if (ack == ack_rx) begin
            build_packet(len, pkt);
            foreach (pkt[k]) begin
               rx_model[q].push_back(pkt[k]);
               n2c_expect.push_back(pkt[k].data);
            end
         end
         if (ack == ack_rx && hold > 0)
            dma_dest_q_nearly_full_c2n = 1'b1;
         issue_op(op, q, ack);
         // an op while this transfer is still open
         if (ack != ack_reject && i + 1 < line_cnt && busy_line(i + 1)) begin
            i++;
            issue_op(dma_op_e'(test_mem[i*line_words][1:0]),
                     test_mem[i*line_words+1][queue_w-1:0], ack_reject);
            exp_stat[4]++;
         end
         case (ack)
            ack_tx: begin
               exp_stat[0]++;
               exp_stat[1] += len;
               run_tx(q, len);
            end
            ack_rx: begin
               exp_stat[2]++;
               exp_stat[3] += len;
               repeat (hold) @(posedge cpci_clk) #1;
               dma_dest_q_nearly_full_c2n = 1'b0;
            end
            default: exp_stat[4]++;
         endcase
         while (tx_expect.size() != 0 || n2c_expect.size() != 0)
            @(posedge cpci_clk) #1;
         // completion travels through result back to decode
         repeat (3) @(posedge cpci_clk) #1;
      end

      // statistics readback
      for (int a = 0; a < 5; a++) begin
         reg_req  = 1'b1;
         reg_addr = stat_reg_e'(a);
         @(posedge cpci_clk) #1;
         reg_req = 1'b0;
         check_flag("reg_ack", reg_ack, 1'b1);
         check_stat($sformatf("reg_rd_data[%0d]", a), reg_rd_data, exp_stat[a]);
      end
      @(posedge cpci_clk) #1;
      $display("Done: no errors");
      $finish;
   end

   // watchdog, 200 cycles per test line
   initial begin
      #1;
      repeat ((line_cnt + 1) * 200 + 8) @(posedge cpci_clk);
      stop_run("timeout, the test sequence did not finish in time");
   end

endmodule

/* hdl/dma_engine.sv */
// DMA engine top, op decode, transfer execute and result stage
`timescale 1ns/1ns

module dma_engine
   import dma_pkg::*;
(
   input  logic                  cpci_clk,
   input  logic                  rst_n,
   // CPCI op handshake
   input  dma_op_e               dma_op_code_req,
   input  logic [queue_w-1:0]    dma_op_queue_id,
   output dma_ack_e              dma_op_code_ack,
   // CPCI data pins
   input  logic                  dma_vld_c2n,
   input  logic [data_w-1:0]     dma_data_c2n,
   output logic                  dma_vld_n2c,
   output logic [data_w-1:0]     dma_data_n2c,
   input  logic                  dma_dest_q_nearly_full_c2n,
   // CPU rx queues
   input  logic [num_queues-1:0] cpu_q_dma_pkt_avail,
   output logic                  cpu_q_dma_rd,
   output logic [queue_w-1:0]    cpu_q_dma_rd_queue,
   input  logic [data_w-1:0]     cpu_q_dma_rd_data,
   input  logic [ctrl_w-1:0]     cpu_q_dma_rd_ctrl,
   // CPU tx queues
   input  logic [num_queues-1:0] cpu_q_dma_nearly_full,
   output logic                  cpu_q_dma_wr,
   output logic [queue_w-1:0]    cpu_q_dma_wr_queue,
   output logic [data_w-1:0]     cpu_q_dma_wr_data,
   output logic [ctrl_w-1:0]     cpu_q_dma_wr_ctrl,
   output logic                  cpu_q_dma_wr_pkt_vld,
   // statistics read port
   input  logic                  reg_req,
   input  stat_reg_e             reg_addr,
   output logic                  reg_ack,
   output logic [stat_w-1:0]     reg_rd_data
);

   // accepted command, decode to execute
   dma_cmd_if cmd_if ();

   xfer_done_t done;
   logic       rejected;
   logic       xfer_end;

   // ports connect by matching name
   dma_op_decode i_dma_op_decode (
      .cmd (cmd_if.decode),
      .*
   );

   dma_xfer_exec i_dma_xfer_exec (
      .cmd (cmd_if.exec),
      .*
   );

   dma_stat_result i_dma_stat_result (
      .*
   );

endmodule

/* hdl/dma_stat_result.sv */
// transfer statistics, completion pulse, register read port
`timescale 1ns/1ns

module dma_stat_result
   import dma_pkg::*;
(
   input  logic              cpci_clk,
   input  logic              rst_n,
   input  xfer_done_t        done,
   input  logic              rejected,
   input  logic              reg_req,
   input  stat_reg_e         reg_addr,
   output logic              xfer_end,
   output logic [stat_w-1:0] reg_rd_data,
   output logic              reg_ack
);

   logic [stat_w-1:0] tx_pkts;
   logic [stat_w-1:0] tx_bytes;
   logic [stat_w-1:0] rx_pkts;
   logic [stat_w-1:0] rx_bytes;
   logic [stat_w-1:0] rej_ops;

   // counters and control strobes
   always_ff @(posedge cpci_clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_pkts  <= '0;
         tx_bytes <= '0;
         rx_pkts  <= '0;
         rx_bytes <= '0;
         rej_ops  <= '0;
         xfer_end <= 1'b0;
         reg_ack  <= 1'b0;
      end else begin
         // frees decode for the next op
         xfer_end <= done.vld;
         reg_ack  <= reg_req;
         if (done.vld && done.is_rx) begin
            rx_pkts  <= rx_pkts + 1'b1;
            rx_bytes <= rx_bytes + stat_w'(done.len);
         end
         if (done.vld && !done.is_rx) begin
            tx_pkts  <= tx_pkts + 1'b1;
            tx_bytes <= tx_bytes + stat_w'(done.len);
         end
         if (rejected)
            rej_ops <= rej_ops + 1'b1;
      end
   end

   // read mux, unmapped addresses read 0
   always_ff @(posedge cpci_clk) begin
      if (reg_req) begin
         case (reg_addr)
            reg_tx_pkts:  reg_rd_data <= tx_pkts;
            reg_tx_bytes: reg_rd_data <= tx_bytes;
            reg_rx_pkts:  reg_rd_data <= rx_pkts;
            reg_rx_bytes: reg_rd_data <= rx_bytes;
            reg_rejects:  reg_rd_data <= rej_ops;
            default:      reg_rd_data <= '0;
         endcase
      end
   end

endmodule

/* hdl/dma_xfer_exec.sv */
// tx and rx packet word movement between CPCI pins and CPU queues
// one word FIFO per direction
`timescale 1ns/1ns

module dma_xfer_exec
   import dma_pkg::*;
(
   input  logic               cpci_clk,
   input  logic               rst_n,
   dma_cmd_if.exec            cmd,
   input  logic               dma_vld_c2n,
   input  logic [data_w-1:0]  dma_data_c2n,
   input  logic               dma_dest_q_nearly_full_c2n,
   input  logic [data_w-1:0]  cpu_q_dma_rd_data,
   input  logic [ctrl_w-1:0]  cpu_q_dma_rd_ctrl,
   output logic               dma_vld_n2c,
   output logic [data_w-1:0]  dma_data_n2c,
   output logic               cpu_q_dma_rd,
   output logic [queue_w-1:0] cpu_q_dma_rd_queue,
   output logic               cpu_q_dma_wr,
   output logic [queue_w-1:0] cpu_q_dma_wr_queue,
   output logic [data_w-1:0]  cpu_q_dma_wr_data,
   output logic [ctrl_w-1:0]  cpu_q_dma_wr_ctrl,
   output logic               cpu_q_dma_wr_pkt_vld,
   output xfer_done_t         done
);

   // words in a packet from the byte length rounded up
   function automatic logic [len_w-2:0] word_count(input logic [len_w-1:0] len);
      logic [len_w:0] sum;
      sum = {1'b0, len} + (len_w + 1)'(3);
      return sum[len_w:2];
   endfunction

   // one-hot mark of the last valid byte from length mod 4
   function automatic logic [ctrl_w-1:0] last_ctrl(input logic [1:0] rem);
      case (rem)
         2'd1:    return 4'b1000;
         2'd2:    return 4'b0100;
         2'd3:    return 4'b0010;
         default: return 4'b0001;
      endcase
   endfunction

   logic              c2n_vld_q;
   logic [data_w-1:0] c2n_data_q;
   logic              tx_active;
   logic              tx_need_len;
   logic [len_w-2:0]  tx_words_left;
   logic [len_w-1:0]  tx_len;
   logic              tx_fifo_wr;
   logic              tx_last_in;
   logic              tx_pop;
   logic              tx_empty;
   queue_word_t       tx_in;
   queue_word_t       tx_out;

   logic                  rx_active;
   logic                  rx_wait_len;
   logic                  rx_ret;
   logic [len_w-2:0]      rx_rd_left;
   logic [len_w-1:0]      rx_len;
   logic                  rx_space;
   logic                  rx_issue;
   logic                  rx_pop;
   logic                  rx_empty;
   logic [fifo_cnt_w-1:0] rx_count;
   queue_word_t           rx_in;
   queue_word_t           rx_out;

   //////////////////////////////////////////////////////////////////////
   // tx from host to card
   //////////////////////////////////////////////////////////////////////

   // first word holds the length and is not written
   assign tx_fifo_wr = tx_active && !tx_need_len && c2n_vld_q;
   assign tx_last_in = (tx_words_left == 1);
   assign tx_in.data = c2n_data_q;
   assign tx_in.ctrl = tx_last_in ? last_ctrl(tx_len[1:0]) : '0;
   // queue port has no back-pressure so the FIFO drains every cycle
   assign tx_pop     = !tx_empty;

   always_ff @(posedge cpci_clk or negedge rst_n) begin
      if (!rst_n) begin
         c2n_vld_q     <= 1'b0;
         tx_active     <= 1'b0;
         tx_need_len   <= 1'b0;
         tx_words_left <= '0;
      end else begin
         c2n_vld_q <= dma_vld_c2n;
         if (cmd.cmd_vld && !cmd.cmd_is_rx) begin
            tx_active   <= 1'b1;
            tx_need_len <= 1'b1;
         end else if (tx_active && c2n_vld_q) begin
            if (tx_need_len) begin
               tx_need_len   <= 1'b0;
               tx_words_left <= word_count(c2n_data_q[len_w-1:0]);
            end else begin
               tx_words_left <= tx_words_left - 1'b1;
               if (tx_last_in)
                  tx_active <= 1'b0;
            end
         end
      end
   end

   dma_word_fifo #(.payload_t(queue_word_t)) i_tx_fifo (
      .cpci_clk (cpci_clk),
      .rst_n    (rst_n),
      .wr       (tx_fifo_wr),
      .wr_data  (tx_in),
      .rd       (tx_pop),
      .rd_data  (tx_out),
      .empty    (tx_empty),
      .count    ()
   );

   //////////////////////////////////////////////////////////////////////
   // rx from card to host
   //////////////////////////////////////////////////////////////////////

   // word from the queue one cycle after its read strobe
   assign rx_in.data = cpu_q_dma_rd_data;
   assign rx_in.ctrl = cpu_q_dma_rd_ctrl;
   // room for one more word counting reads still on their way back
   assign rx_space = (rx_count + fifo_cnt_w'(cpu_q_dma_rd) + fifo_cnt_w'(rx_ret))
                     < fifo_cnt_w'(fifo_depth);
   assign rx_issue = (rx_rd_left != '0) && rx_space;
   assign rx_pop   = !rx_empty && !dma_dest_q_nearly_full_c2n;

   // first read goes alone and the rest follow the length in the first word
   always_ff @(posedge cpci_clk or negedge rst_n) begin
      if (!rst_n) begin
         cpu_q_dma_rd <= 1'b0;
         rx_ret       <= 1'b0;
         rx_active    <= 1'b0;
         rx_wait_len  <= 1'b0;
         rx_rd_left   <= '0;
      end else begin
         cpu_q_dma_rd <= rx_issue;
         rx_ret       <= cpu_q_dma_rd;
         if (cmd.cmd_vld && cmd.cmd_is_rx) begin
            rx_active   <= 1'b1;
            rx_wait_len <= 1'b1;
            rx_rd_left  <= (len_w - 1)'(1);
         end else begin
            // a word with non-zero ctrl ends reading
            if (rx_ret && cpu_q_dma_rd_ctrl != '0)
               rx_rd_left <= '0;
            else if (rx_ret && rx_wait_len)
               rx_rd_left <= word_count(cpu_q_dma_rd_data[len_w-1:0]) - 1'b1;
            else if (rx_issue)
               rx_rd_left <= rx_rd_left - 1'b1;
            if (rx_ret)
               rx_wait_len <= 1'b0;
            if (rx_pop && rx_out.ctrl != '0)
               rx_active <= 1'b0;
         end
      end
   end

   dma_word_fifo #(.payload_t(queue_word_t)) i_rx_fifo (
      .cpci_clk (cpci_clk),
      .rst_n    (rst_n),
      .wr       (rx_ret),
      .wr_data  (rx_in),
      .rd       (rx_pop),
      .rd_data  (rx_out),
      .empty    (rx_empty),
      .count    (rx_count)
   );

   //////////////////////////////////////////////////////////////////////
   // output registers and completion
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge cpci_clk or negedge rst_n) begin
      if (!rst_n) begin
         cpu_q_dma_wr         <= 1'b0;
         cpu_q_dma_wr_pkt_vld <= 1'b0;
         dma_vld_n2c          <= 1'b0;
         done                 <= '0;
      end else begin
         cpu_q_dma_wr         <= tx_pop;
         cpu_q_dma_wr_pkt_vld <= tx_pop && (tx_out.ctrl != '0);
         dma_vld_n2c          <= rx_pop;
         // last word written or sent
         done.vld   <= (tx_pop && tx_out.ctrl != '0) || (rx_pop && rx_out.ctrl != '0);
         done.is_rx <= rx_pop && (rx_out.ctrl != '0);
         done.len   <= (rx_pop && rx_out.ctrl != '0) ? rx_len : tx_len;
      end
   end

   // payload, queue ids and lengths
   always_ff @(posedge cpci_clk) begin
      c2n_data_q <= dma_data_c2n;
      if (cmd.cmd_vld && !cmd.cmd_is_rx)
         cpu_q_dma_wr_queue <= cmd.cmd_queue;
      if (cmd.cmd_vld && cmd.cmd_is_rx)
         cpu_q_dma_rd_queue <= cmd.cmd_queue;
      if (tx_active && tx_need_len && c2n_vld_q)
         tx_len <= c2n_data_q[len_w-1:0];
      if (rx_ret && rx_wait_len)
         rx_len <= cpu_q_dma_rd_data[len_w-1:0];
      if (tx_pop) begin
         cpu_q_dma_wr_data <= tx_out.data;
         cpu_q_dma_wr_ctrl <= tx_out.ctrl;
      end
      if (rx_pop)
         dma_data_n2c <= rx_out.data;
   end

   // decode sends only after the previous packet has fully left
   a_cmd_when_idle: assert property (@(posedge cpci_clk) disable iff (!rst_n)
      cmd.cmd_vld |-> !tx_active && !rx_active && tx_empty && rx_empty);

endmodule

/* hdl/dma_op_decode.sv */
// op request check against busy and queue status, ack code
// and command strobe toward execute
`timescale 1ns/1ns

module dma_op_decode
   import dma_pkg::*;
(
   input  logic                  cpci_clk,
   input  logic                  rst_n,
   input  dma_op_e               dma_op_code_req,
   input  logic [queue_w-1:0]    dma_op_queue_id,
   input  logic [num_queues-1:0] cpu_q_dma_pkt_avail,
   input  logic [num_queues-1:0] cpu_q_dma_nearly_full,
   input  logic                  xfer_end,
   output dma_ack_e              dma_op_code_ack,
   output logic                  rejected,
   dma_cmd_if.decode             cmd
);

   logic req_tx;
   logic req_rx;
   logic refuse;
   logic accept;
   logic busy;

   assign req_tx = (dma_op_code_req == op_tx);
   assign req_rx = (dma_op_code_req == op_rx);

   // reject rule
   // busy, nothing to read, or no room to write
   always_comb begin
      refuse = busy;
      if (req_rx && !cpu_q_dma_pkt_avail[dma_op_queue_id])
         refuse = 1'b1;
      if (req_tx && cpu_q_dma_nearly_full[dma_op_queue_id])
         refuse = 1'b1;
   end

   assign accept = (req_tx || req_rx) && !refuse;

   always_ff @(posedge cpci_clk or negedge rst_n) begin
      if (!rst_n) begin
         dma_op_code_ack <= ack_none;
         rejected        <= 1'b0;
         cmd.cmd_vld     <= 1'b0;
         busy            <= 1'b0;
      end else begin
         rejected    <= (req_tx || req_rx) && refuse;
         cmd.cmd_vld <= accept;
         // ack held for one cycle only
         if (!(req_tx || req_rx))
            dma_op_code_ack <= ack_none;
         else if (refuse)
            dma_op_code_ack <= ack_reject;
         else if (req_rx)
            dma_op_code_ack <= ack_rx;
         else
            dma_op_code_ack <= ack_tx;
         // busy from acceptance until the result stage reports the end
         if (accept)
            busy <= 1'b1;
         else if (xfer_end)
            busy <= 1'b0;
      end
   end

   // command payload
   always_ff @(posedge cpci_clk) begin
      if (accept) begin
         cmd.cmd_is_rx <= req_rx;
         cmd.cmd_queue <= dma_op_queue_id;
      end
   end

   assign cmd.cmd_len_unused_none = 1'b1;

   // end of transfer only arrives for a command still outstanding
   a_end_while_busy: assert property (@(posedge cpci_clk) disable iff (!rst_n)
      xfer_end |-> busy && !cmd.cmd_vld);

endmodule

/* hdl/dma_word_fifo.sv */
// small synchronous show-ahead FIFO, payload set by type parameter
`timescale 1ns/1ns

module dma_word_fifo
   import dma_pkg::*;
#(
   parameter type payload_t = logic
) (
   input  logic                  cpci_clk,
   input  logic                  rst_n,
   input  logic                  wr,
   input  payload_t              wr_data,
   input  logic                  rd,
   output payload_t              rd_data,
   output logic                  empty,
   output logic [fifo_cnt_w-1:0] count
);

   payload_t                       mem [fifo_depth];
   logic [$clog2(fifo_depth)-1:0] wr_ptr;
   logic [$clog2(fifo_depth)-1:0] rd_ptr;

   // storage, no reset needed
   always_ff @(posedge cpci_clk) begin
      if (wr)
         mem[wr_ptr] <= wr_data;
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge cpci_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head word visible before the pop
   assign rd_data = mem[rd_ptr];
   assign empty   = (count == '0);

   a_no_overflow: assert property (@(posedge cpci_clk) disable iff (!rst_n)
      wr && (count == fifo_cnt_w'(fifo_depth)) |-> rd);
   a_no_underflow: assert property (@(posedge cpci_clk) disable iff (!rst_n)
      rd |-> !empty);

endmodule

/* hdl/dma_cmd_if.sv */
// accepted command from op decode to transfer execute
`timescale 1ns/1ns

interface dma_cmd_if
   import dma_pkg::*;
();

   // one-cycle strobe, execute is idle whenever it fires
   logic               cmd_vld;
   // 0 host to card, 1 card to host
   logic               cmd_is_rx;
   logic [queue_w-1:0] cmd_queue;
   // length always travels in band in the first data word
   logic               cmd_len_unused_none;

   modport decode (
      output cmd_vld,
      output cmd_is_rx,
      output cmd_queue,
      output cmd_len_unused_none
   );

   modport exec (
      input cmd_vld,
      input cmd_is_rx,
      input cmd_queue,
      input cmd_len_unused_none
   );

endinterface

/* hdl/dma_pkg.sv */
// shared sizes, queue word and completion structs
// op, ack and statistics register codes
package dma_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////

   localparam int num_queues = 4;
   localparam int queue_w    = 2;
   localparam int data_w     = 32;
   // one control bit per byte lane
   localparam int ctrl_w     = data_w / 8;
   // byte length field, bits 10:0 of the first word
   localparam int len_w      = 11;
   localparam int fifo_depth = 4;
   // fifo fill level, 0 up to fifo_depth
   localparam int fifo_cnt_w = $clog2(fifo_depth) + 1;
   localparam int stat_w     = 32;
   localparam int reg_addr_w = 3;

   //////////////////////////////////////////////////////////////////////
   // codes
   //////////////////////////////////////////////////////////////////////

   // host request on dma_op_code_req
   typedef enum logic [1:0] {
      op_none = 2'b00,
      op_tx   = 2'b01,
      op_rx   = 2'b10
   } dma_op_e;

   // answer on dma_op_code_ack, one cycle wide
   typedef enum logic [1:0] {
      ack_none   = 2'b00,
      ack_tx     = 2'b01,
      ack_rx     = 2'b10,
      ack_reject = 2'b11
   } dma_ack_e;

   // statistics register map
   typedef enum logic [reg_addr_w-1:0] {
      reg_tx_pkts  = 3'd0,
      reg_tx_bytes = 3'd1,
      reg_rx_pkts  = 3'd2,
      reg_rx_bytes = 3'd3,
      reg_rejects  = 3'd4
   } stat_reg_e;

   // ctrl 0 on middle words, one-hot last valid byte on the last word
   typedef struct packed {
      logic [data_w-1:0] data;
      logic [ctrl_w-1:0] ctrl;
   } queue_word_t;

   // end of packet report toward the result stage
   typedef struct packed {
      logic             is_rx;
      logic [len_w-1:0] len;
      logic             vld;
   } xfer_done_t;

endpackage
